// ==== cpu_bus_pkg.sv ====
/*
 * CPU bus definitions for the 386-style memory port
 * Word width, served address range and where the SDRAM fields sit in the address
 */
package cpu_bus_pkg;

	localparam int CPU_DATA_W = 32;	// CPU data word
	localparam int CPU_ADDR_HI = 22;	// Highest address bit decoded
	localparam int CPU_ADDR_LO = 2;	// Byte bits come in as be_n

	// SDRAM field start bits inside the CPU address
	localparam int BANK_LSB = 21;	// Bank select, 2 bits
	localparam int ROW_LSB = 9;	// Row, 12 bits
	localparam int COL_LSB = 2;	// Word column, 7 bits

	localparam int BYTES_PER_WORD = 4;	// Burst beats per CPU word
	localparam int BEAT_W = $clog2(BYTES_PER_WORD);	// Beat counter width

	// Direction of a CPU memory cycle, taken from W/R
	typedef enum logic {
		OP_READ = 1'b0,
		OP_WRITE = 1'b1
	} cpu_op_e;

endpackage

// ==== sdram_pkg.sv ====
/*
 * SDRAM device definitions
 * Pin widths, command encodings, sequencer states and the mode register word
 */
package sdram_pkg;

	localparam int SDRAM_A_W = 12;	// Address pins
	localparam int SDRAM_DQ_W = 8;	// Data pins, x8 part
	localparam int BA_W = 2;	// Bank pins

	localparam int CAS_LATENCY = 2;	// Read data delay, matches mode word
	localparam int T_RCD = 2;	// ACT to RD/WR

	// BL=4, sequential, CL=2, programmed burst write
	localparam logic [SDRAM_A_W-1:0] MODE_WORD = 12'h022;

	// Encoded as {RAS_n, CAS_n, WE_n}
	typedef enum logic [2:0] {
		CMD_LMR = 3'b000,
		CMD_ARF = 3'b001,
		CMD_PRE = 3'b010,
		CMD_ACT = 3'b011,
		CMD_WR = 3'b100,
		CMD_RD = 3'b101,
		CMD_NOP = 3'b111
	} sdram_cmd_e;

	typedef enum logic [4:0] {
		ST_POWERUP,	// cke low until PLL lock
		ST_INIT_WAIT, ST_INIT_PRE, ST_INIT_TRP,
		ST_INIT_ARF0, ST_INIT_RFC0, ST_INIT_ARF1, ST_INIT_RFC1,
		ST_INIT_LMR, ST_INIT_MRD,
		ST_IDLE,
		ST_REF_ARF, ST_REF_RFC,
		ST_ACT, ST_TRCD,
		ST_WR_BEAT, ST_WR_REC,
		ST_RD_BEAT, ST_RD_PRE, ST_RD_TRP
	} seq_state_e;

endpackage

// ==== cpu_cycle_capture.sv ====
/*
 * CPU cycle capture
 * Accepts one memory strobe at a time and holds it until the sequencer takes it
 */
`timescale 1ns/1ps

module cpu_cycle_capture
	import cpu_bus_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic ads_n,
	input logic cs_n,
	input logic mio,
	input logic wr,
	input logic [CPU_ADDR_HI:CPU_ADDR_LO] addr,
	input logic [BYTES_PER_WORD-1:0] be_n,
	input logic [CPU_DATA_W-1:0] wdata,
	input logic take,
	output logic pending,
	output cpu_op_e op,
	output logic [CPU_ADDR_HI:CPU_ADDR_LO] req_addr,
	output logic [BYTES_PER_WORD-1:0] req_be_n,
	output logic [CPU_DATA_W-1:0] req_wdata
);

	logic accept;

	// Memory cycle only, a second strobe while busy is dropped
	assign accept = !ads_n && !cs_n && mio && !pending;

	always_ff @(posedge CLK) begin
		if (!RESET) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;	// Cycle waiting for the sequencer
		end else if (take) begin
			pending <= 1'b0;	// Sequencer started the access
		end
	end

	// Request fields stay put until the next accepted strobe
	always_ff @(posedge CLK) begin
		if (accept) begin
			op <= cpu_op_e'(wr);	// W/R high means write
			req_addr <= addr;
			req_be_n <= be_n;
			req_wdata <= wdata;	// Ignored on reads
		end
	end

endmodule

// ==== refresh_timer.sv ====
/*
 * Refresh interval timer
 * Reloading down-counter that raises a sticky request until acknowledged
 */
`timescale 1ns/1ps

module refresh_timer #(
	parameter int REFRESH_INTERVAL = 1560
) (
	input logic CLK,
	input logic RESET,
	input logic run,
	input logic ref_ack,
	output logic ref_req
);

	localparam int CNT_W = $clog2(REFRESH_INTERVAL);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge CLK) begin
		if (!RESET || !run) begin
			cnt <= CNT_W'(REFRESH_INTERVAL - 1);	// Held loaded during init
			ref_req <= 1'b0;
		end else begin
			if (cnt == '0) begin
				cnt <= CNT_W'(REFRESH_INTERVAL - 1);	// Free-running period
			end else begin
				cnt <= cnt - 1'b1;
			end
			if (cnt == '0) begin
				ref_req <= 1'b1;	// New expiry wins over a same-cycle ack
			end else if (ref_ack) begin
				ref_req <= 1'b0;
			end
		end
	end

endmodule

// ==== sdram_sequencer.sv ====
/*
 * SDRAM sequencer
 * Power-up sequence, periodic refresh and four-beat read/write bursts
 * One command per cycle, with a shared wait counter for every fixed delay
 */
`timescale 1ns/1ps

module sdram_sequencer
	import cpu_bus_pkg::*;
	import sdram_pkg::*;
#(
	parameter int INIT_WAIT_CYCLES = 10000,
	parameter int T_RP = 2,
	parameter int T_RFC = 7,
	parameter int T_MRD = 2
) (
	input logic CLK,
	input logic RESET,
	input logic lock,
	input logic pending,
	input cpu_op_e op,
	input logic [CPU_ADDR_HI:CPU_ADDR_LO] req_addr,
	input logic [BYTES_PER_WORD-1:0] req_be_n,
	input logic [CPU_DATA_W-1:0] req_wdata,
	input logic ref_req,
	output logic take,
	output logic ref_ack,
	output logic timer_run,
	output logic seq_cke,
	output sdram_cmd_e seq_cmd,
	output logic [SDRAM_A_W-1:0] seq_a,
	output logic [BA_W-1:0] seq_ba,
	output logic seq_dqm,
	output logic [SDRAM_DQ_W-1:0] seq_wbyte,
	output logic seq_wen,
	output logic beat_valid,
	output logic [BEAT_W-1:0] beat_index,
	output logic wr_done
);

	localparam int WAIT_A = (INIT_WAIT_CYCLES > T_RFC) ? INIT_WAIT_CYCLES : T_RFC;
	localparam int CNT_MAX = (WAIT_A > T_RP + 1) ? WAIT_A : T_RP + 1;
	localparam int CNT_W = $clog2(CNT_MAX + 1);
	localparam int COL_W = ROW_LSB - COL_LSB;	// Word column bits
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BYTES_PER_WORD - 1);

	seq_state_e state, state_d;
	logic [CNT_W-1:0] cnt, cnt_d;
	logic [BEAT_W-1:0] beat, beat_d;
	logic init_done;
	logic cnt_zero;
	logic [BA_W-1:0] bank;
	logic [SDRAM_A_W-1:0] row;
	logic [SDRAM_A_W-1:0] col_addr;

	assign bank = req_addr[BANK_LSB +: BA_W];
	assign row = req_addr[ROW_LSB +: SDRAM_A_W];
	// Word column plus two zero bits, a10 left clear
	assign col_addr = {{(SDRAM_A_W - COL_W - 2){1'b0}}, req_addr[COL_LSB +: COL_W], 2'b00};

	assign cnt_zero = (cnt == '0);
	assign seq_cke = (state != ST_POWERUP);	// Clock enable once lock seen
	assign timer_run = init_done;
	assign beat_index = beat;
	assign seq_wbyte = req_wdata[beat*SDRAM_DQ_W +: SDRAM_DQ_W];	// Byte k on beat k

	always_comb begin
		state_d = state;
		cnt_d = cnt_zero ? cnt : cnt - 1'b1;	// Free countdown, states reload it
		beat_d = beat;
		seq_cmd = CMD_NOP;
		seq_a = '0;
		seq_ba = '0;
		seq_dqm = 1'b1;	// Masked outside a burst
		seq_wen = 1'b0;
		beat_valid = 1'b0;
		take = 1'b0;
		ref_ack = 1'b0;
		wr_done = 1'b0;
		case (state)
			ST_POWERUP: if (lock) begin
				state_d = ST_INIT_WAIT;
				cnt_d = CNT_W'(INIT_WAIT_CYCLES - 1);
			end
			ST_INIT_WAIT: if (cnt_zero) state_d = ST_INIT_PRE;
			ST_INIT_PRE: begin
				seq_cmd = CMD_PRE;
				seq_a[10] = 1'b1;	// All banks
				cnt_d = CNT_W'(T_RP - 1);
				state_d = ST_INIT_TRP;
			end
			ST_INIT_TRP: if (cnt_zero) state_d = ST_INIT_ARF0;
			ST_INIT_ARF0, ST_INIT_ARF1: begin
				seq_cmd = CMD_ARF;
				cnt_d = CNT_W'(T_RFC - 1);
				state_d = (state == ST_INIT_ARF0) ? ST_INIT_RFC0 : ST_INIT_RFC1;
			end
			ST_INIT_RFC0: if (cnt_zero) state_d = ST_INIT_ARF1;
			ST_INIT_RFC1: if (cnt_zero) state_d = ST_INIT_LMR;
			ST_INIT_LMR: begin
				seq_cmd = CMD_LMR;
				seq_a = MODE_WORD;
				cnt_d = CNT_W'(T_MRD - 1);
				state_d = ST_INIT_MRD;
			end
			ST_INIT_MRD: if (cnt_zero) state_d = ST_IDLE;
			ST_IDLE: begin
				if (pending) begin	// CPU access ahead of refresh
					take = 1'b1;
					state_d = ST_ACT;
				end else if (ref_req) begin
					ref_ack = 1'b1;
					state_d = ST_REF_ARF;
				end
			end
			ST_REF_ARF: begin
				seq_cmd = CMD_ARF;
				cnt_d = CNT_W'(T_RFC - 1);
				state_d = ST_REF_RFC;
			end
			ST_REF_RFC: if (cnt_zero) state_d = ST_IDLE;
			ST_ACT: begin
				seq_cmd = CMD_ACT;
				seq_a = row;
				seq_ba = bank;
				cnt_d = CNT_W'(T_RCD - 2);	// T_RCD-1 NOPs follow
				state_d = ST_TRCD;
			end
			ST_TRCD: if (cnt_zero) begin
				beat_d = '0;
				state_d = (op == OP_WRITE) ? ST_WR_BEAT : ST_RD_BEAT;
			end
			ST_WR_BEAT: begin
				seq_cmd = (beat == '0) ? CMD_WR : CMD_NOP;
				seq_a = col_addr;
				seq_a[10] = 1'b1;	// Auto-precharge after the burst
				seq_ba = bank;
				seq_dqm = req_be_n[beat];
				seq_wen = 1'b1;	// Drive DQ on every beat
				beat_d = beat + 1'b1;
				if (beat == LAST_BEAT) begin
					cnt_d = CNT_W'(T_RP);	// Write recovery plus tRP
					state_d = ST_WR_REC;
				end
			end
			ST_WR_REC: if (cnt_zero) begin
				wr_done = 1'b1;
				state_d = ST_IDLE;
			end
			ST_RD_BEAT: begin
				seq_cmd = (beat == '0) ? CMD_RD : CMD_NOP;
				seq_a = col_addr;	// a10 low, closed by explicit PRE
				seq_ba = bank;
				seq_dqm = req_be_n[beat];
				beat_valid = 1'b1;
				beat_d = beat + 1'b1;
				if (beat == LAST_BEAT) state_d = ST_RD_PRE;
			end
			ST_RD_PRE: begin
				seq_cmd = CMD_PRE;
				seq_a[10] = 1'b1;
				cnt_d = CNT_W'(T_RP - 1);
				state_d = ST_RD_TRP;
			end
			ST_RD_TRP: if (cnt_zero) state_d = ST_IDLE;
			default: state_d = ST_POWERUP;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RESET) begin
			state <= ST_POWERUP;
			cnt <= '0;
			beat <= '0;
			init_done <= 1'b0;
		end else begin
			state <= state_d;
			cnt <= cnt_d;
			beat <= beat_d;
			if (state == ST_INIT_MRD && cnt_zero) init_done <= 1'b1;	// Refresh timer starts
		end
	end

endmodule

// ==== sdram_pin_driver.sv ====
/*
 * SDRAM pin register stage
 * Every pin is registered once; reset parks the device deselected with cke low
 */
`timescale 1ns/1ps

module sdram_pin_driver
	import sdram_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic seq_cke,
	input sdram_cmd_e seq_cmd,
	input logic [SDRAM_A_W-1:0] seq_a,
	input logic [BA_W-1:0] seq_ba,
	input logic seq_dqm,
	input logic [SDRAM_DQ_W-1:0] seq_wbyte,
	input logic seq_wen,
	output logic cke,
	output logic sdram_cs_n,
	output sdram_cmd_e cmd,
	output logic [SDRAM_A_W-1:0] a,
	output logic [BA_W-1:0] ba,
	output logic dqm,
	output logic [SDRAM_DQ_W-1:0] dq_out,
	output logic dq_oe
);

	// Control pins
	always_ff @(posedge CLK) begin
		if (!RESET) begin
			cke <= 1'b0;
			sdram_cs_n <= 1'b1;	// Deselected
			cmd <= CMD_NOP;
			dqm <= 1'b1;
			dq_oe <= 1'b0;	// DQ released
		end else begin
			cke <= seq_cke;
			sdram_cs_n <= !seq_cke;	// Selected whenever clocked
			cmd <= seq_cmd;
			dqm <= seq_dqm;
			dq_oe <= seq_wen;
		end
	end

	// Address and write data only matter with a command or dq_oe
	always_ff @(posedge CLK) begin
		a <= seq_a;
		ba <= seq_ba;
		dq_out <= seq_wbyte;
	end

endmodule

// ==== read_word_assembler.sv ====
/*
 * Read word assembler
 * Lines up beats with the CAS delay, packs bytes into lanes and pulses READY
 */
`timescale 1ns/1ps

module read_word_assembler
	import cpu_bus_pkg::*;
	import sdram_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic [SDRAM_DQ_W-1:0] dq_in,
	input logic beat_valid,
	input logic [BEAT_W-1:0] beat_index,
	input logic [BYTES_PER_WORD-1:0] req_be_n,
	input logic wr_done,
	output logic [CPU_DATA_W-1:0] rdata,
	output logic ready_n
);

	localparam int DLY = CAS_LATENCY + 1;	// Pin register plus CAS latency

	logic [DLY-1:0] vld_sr;
	logic [BEAT_W-1:0] idx_sr [DLY];
	logic wr_done_q;	// Aligned with the write's last pin cycle
	logic cap_vld;
	logic [BEAT_W-1:0] cap_idx;

	assign cap_vld = vld_sr[DLY-1];	// Byte on dq_in this cycle
	assign cap_idx = idx_sr[DLY-1];

	always_ff @(posedge CLK) begin
		if (!RESET) begin
			vld_sr <= '0;
			wr_done_q <= 1'b0;
			ready_n <= 1'b1;
		end else begin
			vld_sr <= {vld_sr[DLY-2:0], beat_valid};
			wr_done_q <= wr_done;
			// One-cycle READY after last read byte or write recovery
			ready_n <= !((cap_vld && cap_idx == BEAT_W'(BYTES_PER_WORD - 1)) || wr_done_q);
		end
	end

	always_ff @(posedge CLK) begin
		idx_sr[0] <= beat_index;
		for (int i = 1; i < DLY; i++) begin
			idx_sr[i] <= idx_sr[i-1];
		end
		if (cap_vld) begin
			// Disabled lanes read back as zero
			rdata[cap_idx*SDRAM_DQ_W +: SDRAM_DQ_W] <= req_be_n[cap_idx] ? '0 : dq_in;
		end
	end

endmodule

// ==== sdram_controller.sv ====
/*
 * SDRAM controller top level
 * Connects a 386-style CPU memory port to one x8 SDRAM device
 */
`timescale 1ns/1ps

module sdram_controller
	import cpu_bus_pkg::*;
	import sdram_pkg::*;
#(
	parameter int INIT_WAIT_CYCLES = 10000,	// Power-up NOP wait
	parameter int REFRESH_INTERVAL = 1560,
	parameter int T_RP = 2,
	parameter int T_RFC = 7,
	parameter int T_MRD = 2
) (
	input logic CLK,
	input logic RESET,
	input logic ads_n,
	input logic cs_n,
	input logic mio,
	input logic wr,
	input logic [CPU_ADDR_HI:CPU_ADDR_LO] addr,
	input logic [BYTES_PER_WORD-1:0] be_n,
	input logic [CPU_DATA_W-1:0] wdata,
	input logic lock,
	output logic ready_n,
	output logic [CPU_DATA_W-1:0] rdata,
	output logic sdram_clk,
	output logic cke,
	output logic sdram_cs_n,
	output sdram_cmd_e cmd,
	output logic [SDRAM_A_W-1:0] a,
	output logic [BA_W-1:0] ba,
	output logic dqm,
	output logic [SDRAM_DQ_W-1:0] dq_out,
	output logic dq_oe,
	input logic [SDRAM_DQ_W-1:0] dq_in
);

	logic take, pending;
	cpu_op_e op;
	logic [CPU_ADDR_HI:CPU_ADDR_LO] req_addr;
	logic [BYTES_PER_WORD-1:0] req_be_n;
	logic [CPU_DATA_W-1:0] req_wdata;
	logic ref_req, ref_ack, timer_run;
	logic seq_cke, seq_dqm, seq_wen;
	sdram_cmd_e seq_cmd;
	logic [SDRAM_A_W-1:0] seq_a;
	logic [BA_W-1:0] seq_ba;
	logic [SDRAM_DQ_W-1:0] seq_wbyte;
	logic beat_valid, wr_done;
	logic [BEAT_W-1:0] beat_index;

	assign sdram_clk = CLK;	// Device runs on the controller clock

	cpu_cycle_capture cpu_cycle_capture_i (
		.CLK(CLK), .RESET(RESET), .ads_n(ads_n), .cs_n(cs_n), .mio(mio), .wr(wr),
		.addr(addr), .be_n(be_n), .wdata(wdata), .take(take), .pending(pending),
		.op(op), .req_addr(req_addr), .req_be_n(req_be_n), .req_wdata(req_wdata)
	);

	refresh_timer #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) refresh_timer_i (
		.CLK(CLK), .RESET(RESET), .run(timer_run), .ref_ack(ref_ack), .ref_req(ref_req)
	);

	sdram_sequencer #(
		.INIT_WAIT_CYCLES(INIT_WAIT_CYCLES), .T_RP(T_RP), .T_RFC(T_RFC), .T_MRD(T_MRD)
	) sdram_sequencer_i (
		.CLK(CLK), .RESET(RESET), .lock(lock), .pending(pending), .op(op),
		.req_addr(req_addr), .req_be_n(req_be_n), .req_wdata(req_wdata),
		.ref_req(ref_req), .take(take), .ref_ack(ref_ack), .timer_run(timer_run),
		.seq_cke(seq_cke), .seq_cmd(seq_cmd), .seq_a(seq_a), .seq_ba(seq_ba),
		.seq_dqm(seq_dqm), .seq_wbyte(seq_wbyte), .seq_wen(seq_wen),
		.beat_valid(beat_valid), .beat_index(beat_index), .wr_done(wr_done)
	);

	sdram_pin_driver sdram_pin_driver_i (
		.CLK(CLK), .RESET(RESET), .seq_cke(seq_cke), .seq_cmd(seq_cmd), .seq_a(seq_a),
		.seq_ba(seq_ba), .seq_dqm(seq_dqm), .seq_wbyte(seq_wbyte), .seq_wen(seq_wen),
		.cke(cke), .sdram_cs_n(sdram_cs_n), .cmd(cmd), .a(a), .ba(ba), .dqm(dqm),
		.dq_out(dq_out), .dq_oe(dq_oe)
	);

	read_word_assembler read_word_assembler_i (
		.CLK(CLK), .RESET(RESET), .dq_in(dq_in), .beat_valid(beat_valid),
		.beat_index(beat_index), .req_be_n(req_be_n), .wr_done(wr_done),
		.rdata(rdata), .ready_n(ready_n)
	);

endmodule

// ==== sdram_checker.sv ====
/*
 * SDRAM controller checker
 * Watches the CPU and SDRAM ports and compares them against a word model
 */
`timescale 1ns/1ps

module sdram_checker
	import sdram_pkg::*;
#(
	parameter int REFRESH_INTERVAL = 300,
	parameter int ACCESS_MAX = 16	// Longest access that can hold off a refresh
) (
	input logic CLK,
	input logic RESET,
	input logic ads_n,
	input logic cs_n,
	input logic mio,
	input logic wr,
	input logic [22:2] addr,
	input logic [3:0] be_n,
	input logic [31:0] wdata,
	input logic ready_n,
	input logic [31:0] rdata,
	input logic sdram_clk,
	input logic cke,
	input logic sdram_cs_n,
	input sdram_cmd_e cmd,
	input logic [11:0] a,
	input logic [1:0] ba,
	input logic dqm,
	input logic [7:0] dq_out,
	input logic dq_oe,
	output int errors,
	output int accesses,
	output int refreshes
);

	logic [31:0] model [int];	// Word per CPU address
	int err_count = 0;
	int done_count = 0;
	int ref_count = 0;
	logic cur_valid = 1'b0;	// Accepted cycle waiting for READY
	logic cur_wr;
	logic [22:2] cur_addr;
	logic [3:0] cur_be_n;
	logic [31:0] cur_wdata;
	logic in_burst = 1'b0;
	logic burst_seen;
	logic rst_q = 1'b0;
	logic ready_q = 1'b0;
	int init_step = 0;	// PRE, ARF, ARF, LMR seen so far
	int beat;
	int since_arf = 0;

	assign errors = err_count;
	assign accesses = done_count;
	assign refreshes = ref_count;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
			err_count++;
		end
	endtask

	task automatic raise_fault(input string msg);
		$display("%0t: %s", $time, msg);
		err_count++;
	endtask

	// Same fill rule as the memory in the testbench
	function automatic logic [7:0] fill_byte(input logic [22:0] key);
		return key[7:0] ^ key[15:8] ^ {1'b0, key[22:16]} ^ 8'h5a;
	endfunction

	function automatic logic [31:0] model_word(input logic [22:2] wa);
		logic [31:0] w;
		if (model.exists(wa)) begin
			w = model[wa];
		end else begin
			for (int k = 0; k < 4; k++) begin
				w[k*8 +: 8] = fill_byte({wa, 2'(k)});	// Never written
			end
		end
		return w;
	endfunction

	// Clock copy sampled 1 ns after each CLK edge
	always @(CLK) begin : clk_copy
		#1;
		check_value("sdram_clk", sdram_clk, CLK);
	end

	always @(posedge CLK) begin : watch
		logic [31:0] exp_word;
		if (rst_q) begin	// Outputs set by a reset edge
			check_value("ready_n", ready_n, 1);
			check_value("dq_oe", dq_oe, 0);
			check_value("cke", cke, 0);
			check_value("sdram_cs_n", sdram_cs_n, 1);
			check_value("cmd", 32'(cmd), 32'(CMD_NOP));
		end
		rst_q = !RESET;
		if (!RESET) begin
			cur_valid = 1'b0;
			in_burst = 1'b0;
			ready_q = 1'b0;
			init_step = 0;
			since_arf = 0;
		end else begin
			if (!ads_n && !cs_n && mio && !cur_valid) begin
				cur_valid = 1'b1;
				cur_wr = wr;
				cur_addr = addr;
				cur_be_n = be_n;
				cur_wdata = wdata;
				burst_seen = 1'b0;
				if (wr) begin	// Merge enabled bytes
					exp_word = model_word(addr);
					for (int k = 0; k < 4; k++) begin
						if (!be_n[k]) exp_word[k*8 +: 8] = wdata[k*8 +: 8];
					end
					model[addr] = exp_word;
				end
			end
			if (cke && !sdram_cs_n) begin
				case (cmd)
					CMD_PRE: begin
						check_value("a10", a[10], 1);	// Always precharge all
						if (init_step == 0) init_step = 1;
						else if (init_step < 4) raise_fault("PRE out of order during init");
					end
					CMD_ARF: begin
						if (init_step == 1 || init_step == 2) init_step++;
						else if (init_step < 4) raise_fault("ARF out of order during init");
						else ref_count++;
						since_arf = 0;
					end
					CMD_LMR: begin
						if (init_step != 3) raise_fault("LMR out of order");
						check_value("a", a, 12'h022);
						init_step = 4;
						since_arf = 0;
					end
					CMD_ACT: begin
						if (init_step < 4) raise_fault("ACT before the mode register was loaded");
						else if (!cur_valid) raise_fault("ACT without an accepted CPU cycle");
						else begin
							check_value("ba", ba, cur_addr[22:21]);
							check_value("a", a, cur_addr[20:9]);	// Row
						end
					end
					CMD_WR, CMD_RD: begin
						if (!cur_valid || init_step < 4) begin
							raise_fault("burst command without an accepted CPU cycle");
						end else begin
							check_value("cmd", 32'(cmd), cur_wr ? 32'(CMD_WR) : 32'(CMD_RD));
							check_value("ba", ba, cur_addr[22:21]);
							check_value("a", a[8:0], {cur_addr[8:2], 2'b00});	// Column
							check_value("a10", a[10], cur_wr);	// Auto-precharge on writes
							in_burst = 1'b1;
							burst_seen = 1'b1;
							beat = 0;
						end
					end
					CMD_NOP: ;
					default: raise_fault("unexpected SDRAM command");
				endcase
			end
			if (in_burst) begin	// Beat k carries lane k
				check_value("dqm", dqm, cur_be_n[beat]);
				check_value("dq_oe", dq_oe, cur_wr);
				if (cur_wr) check_value("dq_out", dq_out, cur_wdata[beat*8 +: 8]);
				beat++;
				if (beat == 4) in_burst = 1'b0;
			end else if (dq_oe) begin
				raise_fault("dq_oe high outside a write burst");
			end
			if (dq_oe && cmd != CMD_WR && cmd != CMD_NOP) begin
				raise_fault("DQ driven during a command other than WR or NOP");
			end
			if (init_step == 4 && cmd != CMD_ARF && cmd != CMD_LMR) since_arf++;
			if (since_arf == REFRESH_INTERVAL + ACCESS_MAX) begin
				raise_fault("gap between refresh commands too long");
			end
			if (!ready_n) begin
				if (ready_q) raise_fault("ready_n low for more than one cycle");
				else if (!cur_valid) raise_fault("ready_n pulse without an accepted CPU cycle");
				else begin
					if (!burst_seen || in_burst) raise_fault("ready_n before the burst finished");
					if (!cur_wr) begin
						exp_word = model_word(cur_addr);
						for (int k = 0; k < 4; k++) begin
							if (cur_be_n[k]) exp_word[k*8 +: 8] = 8'h00;	// Disabled lane
						end
						check_value("rdata", rdata, exp_word);
					end
					cur_valid = 1'b0;
					done_count++;
				end
			end
			ready_q = !ready_n;
		end
	end

endmodule

// ==== sdram_controller_sva.sv ====
/*
 * SDRAM controller pin protocol assertions
 * Bound into the controller top level
 */
`timescale 1ns/1ps

module sdram_controller_sva
	import sdram_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic ready_n,
	input logic dq_oe,
	input logic cke,
	input sdram_cmd_e cmd
);

	// READY is a single-cycle pulse
	ready_single_cycle: assert property (@(posedge CLK) disable iff (!RESET)
		!ready_n |=> ready_n)
		else $error("ready_n held low for more than one cycle");

	// DQ is only driven with a write burst on the bus
	dq_drive_cmd: assert property (@(posedge CLK) disable iff (!RESET)
		dq_oe |-> (cmd == CMD_WR || cmd == CMD_NOP))
		else $error("dq_oe high with a command other than WR or NOP");

	// Device stays unclocked in reset
	cke_low_in_reset: assert property (@(posedge CLK) !RESET |=> !cke)
		else $error("cke high while RESET is low");

endmodule

bind sdram_controller sdram_controller_sva sdram_controller_sva_i (
	.CLK(CLK),
	.RESET(RESET),
	.ready_n(ready_n),
	.dq_oe(dq_oe),
	.cke(cke),
	.cmd(cmd)
);

// ==== tb_sdram_controller.sv ====
/*
 * SDRAM controller testbench
 * Random CPU reads and writes over a small address set, behavioral x8 SDRAM
 */
`timescale 1ns/1ps

module tb_sdram_controller
	import sdram_pkg::*;
;

	localparam int INIT_WAIT = 200;
	localparam int REFRESH = 300;
	localparam int NUM_ACCESSES = 40;
	localparam int MIN_REFRESHES = 3;	// Run spans at least this many intervals
	localparam int ACCESS_TIMEOUT = 100;

	logic CLK;
	logic RESET = 1'b0;
	logic ads_n = 1'b1;
	logic cs_n = 1'b1;
	logic mio = 1'b0;
	logic wr = 1'b0;
	logic [22:2] addr = '0;
	logic [3:0] be_n = 4'hf;
	logic [31:0] wdata = '0;
	logic lock = 1'b0;
	logic [7:0] dq_in = '0;
	logic ready_n, sdram_clk, cke, sdram_cs_n, dqm, dq_oe;
	logic [31:0] rdata;
	sdram_cmd_e cmd;
	logic [11:0] a;
	logic [1:0] ba;
	logic [7:0] dq_out;
	int errors, accesses, refreshes;
	int seed;
	int tb_errors = 0;
	logic hung = 1'b0;	// A wait ran out

	// Behavioral SDRAM state
	logic [7:0] sdram_mem [int];
	logic [11:0] open_row [4];
	logic [1:0] burst_bank;
	logic [8:0] burst_col;
	logic burst_wr;
	int burst_left = 0;
	logic rd_pend = 1'b0;
	logic [7:0] rd_byte;

	sdram_controller #(
		.INIT_WAIT_CYCLES(INIT_WAIT),
		.REFRESH_INTERVAL(REFRESH)
	) sdram_controller_i (
		.CLK(CLK), .RESET(RESET), .ads_n(ads_n), .cs_n(cs_n), .mio(mio), .wr(wr),
		.addr(addr), .be_n(be_n), .wdata(wdata), .lock(lock), .ready_n(ready_n),
		.rdata(rdata), .sdram_clk(sdram_clk), .cke(cke), .sdram_cs_n(sdram_cs_n),
		.cmd(cmd), .a(a), .ba(ba), .dqm(dqm), .dq_out(dq_out), .dq_oe(dq_oe),
		.dq_in(dq_in)
	);

	sdram_checker #(.REFRESH_INTERVAL(REFRESH)) checker_i (
		.CLK(CLK), .RESET(RESET), .ads_n(ads_n), .cs_n(cs_n), .mio(mio), .wr(wr),
		.addr(addr), .be_n(be_n), .wdata(wdata), .ready_n(ready_n), .rdata(rdata),
		.sdram_clk(sdram_clk), .cke(cke), .sdram_cs_n(sdram_cs_n), .cmd(cmd), .a(a),
		.ba(ba), .dqm(dqm), .dq_out(dq_out), .dq_oe(dq_oe), .errors(errors),
		.accesses(accesses), .refreshes(refreshes)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;	// 40 ns period
	end

	function automatic logic [7:0] fill_byte(input logic [22:0] key);
		return key[7:0] ^ key[15:8] ^ {1'b0, key[22:16]} ^ 8'h5a;	// Folds every address bit
	endfunction

	function automatic logic [7:0] mem_read(input logic [22:0] key);
		if (sdram_mem.exists(key)) return sdram_mem[key];
		return fill_byte(key);
	endfunction

	// Bank, row and column fields spread over the address set
	function automatic logic [22:2] pick_addr(input int idx);
		case (idx)
			0: return {2'd0, 12'h000, 7'h00};
			1: return {2'd0, 12'h000, 7'h01};	// Same row as 0
			2: return {2'd1, 12'h3a5, 7'h7f};
			3: return {2'd2, 12'hfff, 7'h40};
			4: return {2'd3, 12'h123, 7'h15};
			default: return {2'd1, 12'h3a5, 7'h02};
		endcase
	endfunction

	// Pins sampled as they were in the cycle just ended, read data back CL=2 later
	always @(posedge CLK) begin : sdram_model
		logic [22:0] key;
		dq_in <= rd_pend ? rd_byte : 8'h00;
		rd_pend <= 1'b0;
		if (!RESET) begin
			burst_left = 0;
		end else if (cke && !sdram_cs_n) begin
			case (cmd)
				CMD_ACT: open_row[ba] = a;
				CMD_WR, CMD_RD: begin
					burst_bank = ba;
					burst_col = a[8:0];
					burst_wr = (cmd == CMD_WR);
					burst_left = 4;
				end
				default: ;
			endcase
			if (burst_left > 0) begin
				key = {burst_bank, open_row[burst_bank], burst_col + 9'(4 - burst_left)};
				if (burst_wr) begin
					if (dq_oe && !dqm) sdram_mem[key] = dq_out;	// Masked bytes kept
				end else begin
					rd_pend <= 1'b1;
					rd_byte <= mem_read(key);
				end
				burst_left--;
			end
		end
	end

	task automatic wait_for_init();
		int waited;
		waited = 0;
		while (cmd !== CMD_LMR && waited < INIT_WAIT + 100) begin
			@(posedge CLK);
			waited++;
		end
		if (cmd !== CMD_LMR) begin
			$display("Timeout waiting for the mode register load");
			hung = 1'b1;
			tb_errors++;
		end
	endtask

	task automatic run_access(input logic is_wr, input logic [22:2] wa,
		input logic [3:0] ben, input logic [31:0] wd);
		int waited;
		@(posedge CLK);
		ads_n <= 1'b0;
		cs_n <= 1'b0;
		mio <= 1'b1;
		wr <= is_wr;
		addr <= wa;
		be_n <= ben;
		wdata <= wd;
		@(posedge CLK);
		ads_n <= 1'b1;	// One-cycle strobe
		cs_n <= 1'b1;
		waited = 0;
		while (ready_n !== 1'b0 && waited < ACCESS_TIMEOUT) begin
			@(posedge CLK);
			waited++;
		end
		if (ready_n !== 1'b0) begin
			$display("Timeout waiting for ready_n after the cycle at %h", wa);
			hung = 1'b1;
			tb_errors++;
		end
	endtask

	initial begin
		logic op_wr;
		logic [3:0] ben;
		logic [31:0] wd;
		int idx;
		seed = 33;
		repeat (2) @(posedge CLK);
		RESET <= 1'b1;
		repeat (5) @(posedge CLK);
		lock <= 1'b1;
		wait_for_init();
		for (int i = 0; i < NUM_ACCESSES && !hung; i++) begin
			op_wr = 1'($random(seed));
			idx = $unsigned($random(seed)) % 6;
			ben = 4'($random(seed));
			wd = $random(seed);
			run_access(op_wr, pick_addr(idx), ben, wd);
			repeat ($unsigned($random(seed)) % 8) @(posedge CLK);	// Idle gap
		end
		if (!hung) repeat (2 * REFRESH) @(posedge CLK);	// Refresh keeps running
		if (!hung && accesses != NUM_ACCESSES) begin
			$display("Only %0d of %0d CPU cycles completed", accesses, NUM_ACCESSES);
			tb_errors++;
		end
		if (!hung && refreshes < MIN_REFRESHES) begin
			$display("Too few refresh commands after init: %0d", refreshes);
			tb_errors++;
		end
		$display("Checker errors %0d, testbench errors %0d, accesses %0d, refreshes %0d",
			errors, tb_errors, accesses, refreshes);
		if (errors == 0 && tb_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== sdram_controller.f ====
cpu_bus_pkg.sv
sdram_pkg.sv
cpu_cycle_capture.sv
refresh_timer.sv
sdram_sequencer.sv
sdram_pin_driver.sv
read_word_assembler.sv
sdram_controller.sv
sdram_checker.sv
sdram_controller_sva.sv
tb_sdram_controller.sv
